// File: rtl/mul_op_pkg.sv
package mul_op_pkg;

	// register width of the core
	localparam int XLEN = 32;

	// operands after sign/zero extension, one extra bit so that all four
	// operations become a single signed multiply
	localparam int OPND_W = XLEN + 1;

	// multiply operations, encoded like the low bits of funct3
	typedef enum logic [1:0]
	{
		MUL    = 2'd0, // low word, signed x signed
		MULH   = 2'd1, // high word, signed x signed
		MULHSU = 2'd2, // high word, signed x unsigned
		MULHU  = 2'd3  // high word, unsigned x unsigned
	} mul_op_e;

endpackage

// File: rtl/mul_sched_pkg.sv
package mul_sched_pkg;

	// one-hot control steps per multiply
	localparam int MUL_STEPS = 7;

	// width of the signed multiplier inputs
	localparam int PART_W = 18;

	// signed multiplier product
	localparam int PROD_W = 2 * PART_W;

	// accumulator holds product bits 64..17
	localparam int ACC_W = 48;

	// unsigned low slice of each operand
	localparam int LOW_W = 17;

endpackage

// File: rtl/mul_operand_prep.sv
`timescale 1ns/1ps

module mul_operand_prep (
	input  mul_op_pkg::mul_op_e             op,
	input  logic [mul_op_pkg::XLEN-1:0]     rs1,
	input  logic [mul_op_pkg::XLEN-1:0]     rs2,
	output logic [mul_op_pkg::OPND_W-1:0]   opnd_a,
	output logic [mul_op_pkg::OPND_W-1:0]   opnd_b,
	output logic                            hi_sel
);
	import mul_op_pkg::*;

	logic sign_a; // rs1 treated as signed
	logic sign_b; // rs2 treated as signed

	always_comb
	begin
		sign_a = 1'b1;
		sign_b = 1'b1;
		hi_sel = 1'b1;
		case (op)
			MUL:
			begin
				hi_sel = 1'b0; // only the low word
			end
			MULH:
			begin
				sign_b = 1'b1;
			end
			MULHSU:
			begin
				sign_b = 1'b0;
			end
			MULHU:
			begin
				sign_a = 1'b0;
				sign_b = 1'b0;
			end
			default:
			begin
				hi_sel = 1'b0;
			end
		endcase
	end

	assign opnd_a = {sign_a & rs1[XLEN-1], rs1};
	assign opnd_b = {sign_b & rs2[XLEN-1], rs2};

endmodule

// File: rtl/reg_fifo.sv
`timescale 1ns/1ps

module reg_fifo #(
	parameter int DEPTH = 2,
	parameter int WIDTH = 8
)(
	input  logic             clk,
	input  logic             resetn,
	input  logic             wen,
	input  logic [WIDTH-1:0] din,
	output logic             full_n,
	input  logic             ren,
	output logic [WIDTH-1:0] dout,
	output logic             empty_n
);
	// a depth of one still needs a one-bit pointer
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // items stored
	logic             do_wr;
	logic             do_rd;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1))
			nxt = '0;
		else
			nxt = ptr + 1'b1;
		return nxt;
	endfunction

	assign do_wr = wen & full_n; // writes when full are dropped
	assign do_rd = ren & empty_n;

	assign full_n = (count != CNT_W'(DEPTH));
	assign empty_n = (count != '0);
	assign dout = mem[rd_ptr]; // head shows without a read

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none or both
			endcase
		end
	end

endmodule

// File: rtl/dsp_mul18.sv
`timescale 1ns/1ps

module dsp_mul18 (
	input  logic                                       clk,
	input  logic                                       resetn,
	input  logic signed [mul_sched_pkg::PART_W-1:0]    a,
	input  logic signed [mul_sched_pkg::PART_W-1:0]    b,
	input  logic                                       ce_mul,
	input  logic                                       ce_out,
	output logic signed [mul_sched_pkg::PROD_W-1:0]    p
);
	import mul_sched_pkg::*;

	logic signed [PROD_W-1:0] prod_q; // first stage, raw product

	// two registers, so the product appears two enabled edges later
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			prod_q <= '0;
			p <= '0;
		end
		else
		begin
			if (ce_mul)
				prod_q <= a * b;
			if (ce_out)
				p <= prod_q; // output stage
		end
	end

endmodule

// File: rtl/multicycle_mul.sv
`timescale 1ns/1ps

module multicycle_mul (
	input  logic                                       clk,
	input  logic                                       resetn,
	// buffer head
	input  logic [mul_op_pkg::OPND_W-1:0]              opnd_a,
	input  logic [mul_op_pkg::OPND_W-1:0]              opnd_b,
	input  logic                                       hi_sel,
	input  logic                                       head_valid,
	output logic                                       pop,
	// 18x18 multiplier beside this block
	output logic signed [mul_sched_pkg::PART_W-1:0]    mul_a,
	output logic signed [mul_sched_pkg::PART_W-1:0]    mul_b,
	output logic                                       mul_ce,
	output logic                                       mul_ce_out,
	input  logic signed [mul_sched_pkg::PROD_W-1:0]    mul_p,
	// result handshake
	output logic [mul_op_pkg::XLEN-1:0]                res_data,
	output logic                                       res_valid,
	input  logic                                       res_ready
);
	import mul_op_pkg::*;
	import mul_sched_pkg::*;

	localparam int HIGH_W = OPND_W - LOW_W;  // 16 bits above the low slice
	localparam int FULL_W = ACC_W + LOW_W;   // 65-bit assembled product

	logic [MUL_STEPS-1:0] step;       // one-hot controller
	logic                 advance;
	logic                 res_in_ready;
	logic [PART_W-1:0]    a_lo;
	logic [PART_W-1:0]    a_hi;
	logic [PART_W-1:0]    b_lo;
	logic [PART_W-1:0]    b_hi;
	logic [ACC_W-1:0]     acc;
	logic [ACC_W-1:0]     acc_in;
	logic [LOW_W-1:0]     low_bits;   // product bits 16..0
	logic [FULL_W-1:0]    product;
	logic [XLEN-1:0]      res_word;

	// operand slices, low ones unsigned and high ones signed
	assign a_lo = {{(PART_W - LOW_W){1'b0}}, opnd_a[LOW_W-1:0]};
	assign b_lo = {{(PART_W - LOW_W){1'b0}}, opnd_b[LOW_W-1:0]};
	assign a_hi = {{(PART_W - HIGH_W){opnd_a[OPND_W-1]}}, opnd_a[OPND_W-1:LOW_W]};
	assign b_hi = {{(PART_W - HIGH_W){opnd_b[OPND_W-1]}}, opnd_b[OPND_W-1:LOW_W]};

	// step 0 ll, 1 hl, 2 lh, 3 hh
	assign mul_a = (step[0] | step[2]) ? a_lo : a_hi;
	assign mul_b = (step[0] | step[1]) ? b_lo : b_hi;
	assign mul_ce = (step[0] & head_valid) | step[1] | step[2] | step[3];

	// output stage follows the product stage by one cycle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			mul_ce_out <= 1'b0;
		else
			mul_ce_out <= mul_ce;
	end

	// result register can take a word when empty or being drained
	assign res_in_ready = ~res_valid | res_ready;

	// waits in step 0 for a request and in the last step for the result register
	assign advance = (step[0] & head_valid) |
		(~step[0] & ~step[MUL_STEPS-1]) |
		(step[MUL_STEPS-1] & res_in_ready);

	assign pop = step[MUL_STEPS-1] & res_in_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			step <= MUL_STEPS'(1);
		else if (advance)
			step <= {step[MUL_STEPS-2:0], step[MUL_STEPS-1]};
	end

	// partial products arrive two cycles after their step
	always_comb
	begin
		acc_in = '0;
		if (step[2])
			acc_in = {{(ACC_W - (PROD_W - LOW_W)){1'b0}}, mul_p[PROD_W-1:LOW_W]};
		else if (step[3] | step[4])
			acc_in = {{(ACC_W - PROD_W){mul_p[PROD_W-1]}}, mul_p}; // cross terms
		else if (step[5])
			acc_in = {mul_p[ACC_W-LOW_W-1:0], {LOW_W{1'b0}}}; // hh << 17
	end

	always_ff @(posedge clk)
	begin
		if (step[1])
			acc <= '0;
		else if (step[2] | step[3] | step[4] | step[5])
			acc <= acc + acc_in;
	end

	always_ff @(posedge clk)
	begin
		if (step[2])
			low_bits <= mul_p[LOW_W-1:0]; // never touched again
	end

	assign product = {acc, low_bits};
	assign res_word = hi_sel ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

	// result register, holds under back-pressure
	always_ff @(posedge clk)
	begin
		if (step[MUL_STEPS-1] & res_in_ready)
			res_data <= res_word;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			res_valid <= 1'b0;
		else if (res_in_ready)
			res_valid <= step[MUL_STEPS-1];
	end

endmodule

// File: rtl/mul_unit_top.sv
`timescale 1ns/1ps

module mul_unit_top #(
	parameter int IN_BUF_DEPTH = 2
)(
	input  logic                            clk,
	input  logic                            resetn,
	input  mul_op_pkg::mul_op_e             req_op,
	input  logic [mul_op_pkg::XLEN-1:0]     req_rs1,
	input  logic [mul_op_pkg::XLEN-1:0]     req_rs2,
	input  logic                            req_valid,
	output logic                            req_ready,
	output logic [mul_op_pkg::XLEN-1:0]     res_data,
	output logic                            res_valid,
	input  logic                            res_ready
);
	import mul_op_pkg::*;
	import mul_sched_pkg::*;

	localparam int BUF_W = 1 + 2 * OPND_W; // {b, a, hi_sel}

	logic [OPND_W-1:0]        prep_a;
	logic [OPND_W-1:0]        prep_b;
	logic                     prep_hi;
	logic                     buf_wen;
	logic [BUF_W-1:0]         buf_din;
	logic [BUF_W-1:0]         buf_dout;
	logic                     buf_empty_n;
	logic                     buf_ren;
	logic signed [PART_W-1:0] mul_a;
	logic signed [PART_W-1:0] mul_b;
	logic                     mul_ce;
	logic                     mul_ce_out;
	logic signed [PROD_W-1:0] mul_p;

	mul_operand_prep u_prep (
		.op     (req_op),
		.rs1    (req_rs1),
		.rs2    (req_rs2),
		.opnd_a (prep_a),
		.opnd_b (prep_b),
		.hi_sel (prep_hi)
	);

	assign buf_wen = req_valid & req_ready;
	assign buf_din = {prep_b, prep_a, prep_hi};

	reg_fifo #(
		.DEPTH (IN_BUF_DEPTH),
		.WIDTH (BUF_W)
	) u_in_buf (
		.clk     (clk),
		.resetn  (resetn),
		.wen     (buf_wen),
		.din     (buf_din),
		.full_n  (req_ready),
		.ren     (buf_ren),
		.dout    (buf_dout),
		.empty_n (buf_empty_n)
	);

	multicycle_mul u_engine (
		.clk        (clk),
		.resetn     (resetn),
		.opnd_a     (buf_dout[OPND_W:1]),
		.opnd_b     (buf_dout[BUF_W-1:OPND_W+1]),
		.hi_sel     (buf_dout[0]),
		.head_valid (buf_empty_n),
		.pop        (buf_ren),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.mul_ce     (mul_ce),
		.mul_ce_out (mul_ce_out),
		.mul_p      (mul_p),
		.res_data   (res_data),
		.res_valid  (res_valid),
		.res_ready  (res_ready)
	);

	dsp_mul18 u_mul18 (
		.clk    (clk),
		.resetn (resetn),
		.a      (mul_a),
		.b      (mul_b),
		.ce_mul (mul_ce),
		.ce_out (mul_ce_out),
		.p      (mul_p)
	);

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 4
)(
	output logic clk,
	output logic resetn
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset low for a few edges, released away from the rising edge
	initial
	begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

// File: sim/mul_checker.sv
`timescale 1ns/1ps

module mul_checker (
	input  logic                        clk,
	input  logic                        resetn,
	input  mul_op_pkg::mul_op_e         req_op,
	input  logic [mul_op_pkg::XLEN-1:0] req_rs1,
	input  logic [mul_op_pkg::XLEN-1:0] req_rs2,
	input  logic                        req_valid,
	input  logic                        req_ready,
	input  logic [mul_op_pkg::XLEN-1:0] res_data,
	input  logic                        res_valid,
	input  logic                        res_ready,
	input  logic                        done,
	output int                          err_count,
	output int                          req_count,
	output int                          res_count,
	output int                          pending
);
	import mul_op_pkg::*;

	localparam int RES_LATENCY = 7; // accept edge to the edge that loads the result

	logic [XLEN-1:0] exp_q[$];
	logic [XLEN-1:0] exp_val;
	logic [XLEN-1:0] held_data;
	logic            held;           // result was stalled at the last edge
	logic            reset_checked;
	logic            done_seen;
	logic            track_on;
	int              track_start;
	int              cycle;

	// full 64-bit product, operands widened by the M-extension signedness rules
	function automatic logic [XLEN-1:0] ref_mul(input mul_op_e op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [63:0] wa;
		logic [63:0] wb;
		logic [63:0] prod;
		wa = (op == MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
		wb = (op == MUL || op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
		prod = wa * wb; // modulo 2^64 is all that is needed
		return (op == MUL) ? prod[31:0] : prod[63:32];
	endfunction

	initial
	begin
		err_count = 0;
		req_count = 0;
		res_count = 0;
		pending = 0;
		held = 1'b0;
		held_data = '0;
		reset_checked = 1'b0;
		done_seen = 1'b0;
		track_on = 1'b0;
		track_start = 0;
		cycle = 0;
	end

	always @(posedge clk)
	begin
		if (resetn)
		begin
			cycle = cycle + 1;
			if (!reset_checked)
			begin
				reset_checked = 1'b1;
				if (res_valid !== 1'b0)
				begin
					$display("Mismatch at %0t: res_valid got %b, expected 0", $time, res_valid);
					err_count++;
				end
				if (req_ready !== 1'b1)
				begin
					$display("Mismatch at %0t: req_ready got %b, expected 1", $time, req_ready);
					err_count++;
				end
			end
			if (held)
			begin
				if (res_valid !== 1'b1)
				begin
					$display("Mismatch at %0t: res_valid got %b, expected 1", $time, res_valid);
					err_count++;
				end
				else if (res_data !== held_data)
				begin
					$display("Mismatch at %0t: res_data got %h, expected %h (stalled)",
						$time, res_data, held_data);
					err_count++;
				end
			end
			held = res_valid & ~res_ready;
			held_data = res_data;
			// first rise of res_valid after an isolated request
			if (track_on && res_valid)
			begin
				track_on = 1'b0;
				if (cycle - track_start - 1 != RES_LATENCY)
				begin
					$display("Mismatch at %0t: res_valid latency got %0d, expected %0d",
						$time, cycle - track_start - 1, RES_LATENCY);
					err_count++;
				end
			end
			if (res_valid && res_ready)
			begin
				res_count++;
				if (exp_q.size() == 0)
				begin
					$display("Result %h at %0t arrived with no request waiting", res_data, $time);
					err_count++;
				end
				else
				begin
					exp_val = exp_q.pop_front();
					if (res_data !== exp_val)
					begin
						$display("Mismatch at %0t: res_data got %h, expected %h",
							$time, res_data, exp_val);
						err_count++;
					end
				end
			end
			if (req_valid && req_ready)
			begin
				req_count++;
				if (exp_q.size() == 0 && !res_valid)
				begin
					track_on = 1'b1; // engine idle, latency is fixed
					track_start = cycle;
				end
				exp_q.push_back(ref_mul(req_op, req_rs1, req_rs2));
			end
			pending = exp_q.size();
		end
		if (done && !done_seen)
		begin
			done_seen = 1'b1;
			if (exp_q.size() != 0)
			begin
				$display("%0d requests were still waiting for a result at the end", exp_q.size());
				err_count++;
			end
		end
	end

endmodule

// File: sim/mul_unit_tb.sv
`timescale 1ns/1ps

module mul_unit_tb;
	import mul_op_pkg::*;

	localparam int RAND_REQS = 2000;
	localparam int STALL_REQS = 400;   // random res_ready phase
	localparam int FILL_REQS = 8;      // upper bound for the back-pressure phase
	localparam int TOTAL_REQS = 4 * 36 + RAND_REQS + STALL_REQS + 1 + FILL_REQS;
	localparam int WATCHDOG_CYCLES = TOTAL_REQS * 7 * 4 + 200;
	localparam int DRAIN_CYCLES = 200; // longest wait for the last results

	logic            clk;
	logic            resetn;
	mul_op_e         req_op;
	logic [XLEN-1:0] req_rs1;
	logic [XLEN-1:0] req_rs2;
	logic            req_valid;
	logic            req_ready;
	logic [XLEN-1:0] res_data;
	logic            res_valid;
	logic            res_ready;
	logic            done;
	int              err_count;
	int              req_count;
	int              res_count;
	int              pending;
	int              tb_errors;
	int              ready_mode;   // 0 high, 1 random, 2 low
	logic [31:0]     lfsr;
	logic [31:0]     dir_vals [6];
	logic            dropped;
	logic            ok;

	tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(4)) u_clkgen (
		.clk    (clk),
		.resetn (resetn)
	);

	mul_unit_top #(.IN_BUF_DEPTH(2)) dut (
		.clk       (clk),
		.resetn    (resetn),
		.req_op    (req_op),
		.req_rs1   (req_rs1),
		.req_rs2   (req_rs2),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.res_data  (res_data),
		.res_valid (res_valid),
		.res_ready (res_ready)
	);

	mul_checker u_checker (
		.clk       (clk),
		.resetn    (resetn),
		.req_op    (req_op),
		.req_rs1   (req_rs1),
		.req_rs2   (req_rs2),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.res_data  (res_data),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.done      (done),
		.err_count (err_count),
		.req_count (req_count),
		.res_count (res_count),
		.pending   (pending)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// returns on the accepting edge with req_valid still high for back-to-back use
	task automatic send_req(input mul_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		@(negedge clk);
		req_op = op;
		req_rs1 = a;
		req_rs2 = b;
		req_valid = 1'b1;
		while (!req_ready)
			@(negedge clk);
		@(posedge clk);
	endtask

	task automatic send_random();
		logic [31:0] r_op;
		logic [31:0] r_a;
		logic [31:0] r_b;
		rand_bits(2, r_op);
		rand_bits(32, r_a);
		rand_bits(32, r_b);
		send_req(mul_op_e'(r_op[1:0]), r_a, r_b);
	endtask

	task automatic end_reqs();
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	// gives up after max_cycles so that lost results reach the checker
	task automatic wait_drain(input int max_cycles);
		for (int k = 0; k < max_cycles && pending != 0; k++)
			@(negedge clk);
	endtask

	task automatic wait_req_ready(input int max_cycles, output logic seen);
		seen = 1'b0;
		for (int k = 0; k < max_cycles; k++)
		begin
			@(negedge clk);
			if (req_ready)
			begin
				seen = 1'b1;
				break;
			end
		end
	endtask

	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		ready_mode = mode;
	endtask

	// result-side ready pattern
	initial
	begin
		logic [31:0] r;
		res_ready = 1'b1;
		forever
		begin
			@(negedge clk);
			case (ready_mode)
				1:
				begin
					rand_bits(1, r);
					res_ready = r[0];
				end
				2: res_ready = 1'b0;
				default: res_ready = 1'b1;
			endcase
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the DUT stopped making progress", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		req_op = MUL;
		req_rs1 = '0;
		req_rs2 = '0;
		req_valid = 1'b0;
		done = 1'b0;
		ready_mode = 0;
		tb_errors = 0;
		lfsr = 32'hf5a5;
		dir_vals = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'hffffffff};
		@(posedge resetn);

		// corner values in every pairing
		for (int op = 0; op < 4; op++)
			for (int i = 0; i < 6; i++)
				for (int j = 0; j < 6; j++)
					send_req(mul_op_e'(op[1:0]), dir_vals[i], dir_vals[j]);
		end_reqs();

		for (int n = 0; n < RAND_REQS; n++)
			send_random();
		end_reqs();
		wait_drain(DRAIN_CYCLES);

		set_ready_mode(1);
		for (int n = 0; n < STALL_REQS; n++)
			send_random();
		end_reqs();
		wait_drain(DRAIN_CYCLES);
		set_ready_mode(0);
		wait_drain(DRAIN_CYCLES);

		// isolated request whose latency the checker measures
		send_req(MULHSU, 32'h89abcdef, 32'hfedcba98);
		end_reqs();
		wait_drain(DRAIN_CYCLES);

		set_ready_mode(2);
		dropped = 1'b0;
		for (int n = 0; n < FILL_REQS && !dropped; n++)
		begin
			wait_req_ready(20, ok);
			if (!ok)
				dropped = 1'b1;
			else
			begin
				send_random();
				end_reqs();
			end
		end
		if (!dropped)
		begin
			$display("req_ready never dropped while res_ready was held low");
			tb_errors++;
		end
		set_ready_mode(0);
		wait_drain(DRAIN_CYCLES);

		@(negedge clk);
		done = 1'b1;
		@(posedge clk);
		@(negedge clk);
		$display("requests %0d, results %0d, checker errors %0d, testbench errors %0d",
			req_count, res_count, err_count, tb_errors);
		if (err_count == 0 && tb_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
rtl/mul_op_pkg.sv
rtl/mul_sched_pkg.sv
rtl/mul_operand_prep.sv
rtl/reg_fifo.sv
rtl/dsp_mul18.sv
rtl/multicycle_mul.sv
rtl/mul_unit_top.sv
sim/tb_clkgen.sv
sim/mul_checker.sv
sim/mul_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module mul_unit_tb -f tb.f -o mul_unit_sim
./obj_dir/mul_unit_sim > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
